//--- design/addrTranslator.sv
`timescale 1ns/1ps

module addrTranslator import mmuPkg::*;
(
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input logic vaddrValid,
    input logic [31:0] vaddr,
    input logic [1:0] opType,
    input logic [8:0] crmd,
    input logic [asidWidth-1:0] asid,
    input logic [31:0] dmw0,
    input logic [31:0] dmw1,
    tlbLookupIf.translator lookup,
    output logic [31:0] paddr,
    output logic [1:0] memType,
    output logic [15:0] excArg
);

    logic [5:0] entryPs;
    logic [31:0] psShifted;
    logic oddSel;
    tlbPage_t page;
    logic [31:0] offsetMask;
    logic [31:0] tlbPaddr;
    logic tlbFault;
    logic [5:0] tlbCode;
    logic directMode;
    logic win0Hit;
    logic win1Hit;
    logic [31:0] paddrNext;
    logic [1:0] memTypeNext;
    logic [15:0] excArgNext;

    // plv0 enabled by bit 0, plv3 by bit 3
    function automatic logic windowHit(input logic [31:0] dmw, input logic [31:0] va,
                                       input logic [1:0] plv);
        return ((dmw[0] && plv == 2'd0) || (dmw[3] && plv == 2'd3)) && dmw[31:29] == va[31:29];
    endfunction

    assign lookup.vaddr = vaddr;
    assign lookup.asid = asid;

    assign entryPs = lookup.entry.ps;
    assign psShifted = vaddr >> entryPs;
    assign oddSel = psShifted[0]; // lowest vppn bit picks the half
    assign page = oddSel ? lookup.entry.odd : lookup.entry.even;
    assign offsetMask = ~({32{1'b1}} << entryPs);
    assign tlbPaddr = ({page.ppn, 12'b0} & ~offsetMask) | (vaddr & offsetMask);

    assign directMode = crmd[4:3] == 2'b01; // DA=1 PG=0
    assign win0Hit = windowHit(dmw0, vaddr, crmd[1:0]);
    assign win1Hit = windowHit(dmw1, vaddr, crmd[1:0]);

    always_comb
    begin
        tlbFault = 1'b1;
        tlbCode = excTlbr;
        if (lookup.hit)
        begin
            if (!page.valid)
            begin
                if (opType == opFetch)
                    tlbCode = excPif;
                else if (opType == opStore)
                    tlbCode = excPis;
                else
                    tlbCode = excPil;
            end
            else if (crmd[1:0] > page.plv)
                tlbCode = excPpi;
            else if (opType == opStore && !page.dirty)
                tlbCode = excPme;
            else
                tlbFault = 1'b0;
        end
    end

    always_comb
    begin
        paddrNext = tlbPaddr;
        memTypeNext = page.mat;
        excArgNext = tlbFault ? {vaddrValid, excSubDefault, tlbCode} : '0;
        if (directMode)
        begin
            paddrNext = vaddr;
            memTypeNext = (opType == opFetch) ? crmd[6:5] : crmd[8:7]; // DATF / DATM
            excArgNext = '0;
        end
        else if (win0Hit)
        begin
            paddrNext = {dmw0[27:25], vaddr[28:0]};
            memTypeNext = dmw0[5:4];
            excArgNext = '0;
        end
        else if (win1Hit)
        begin
            paddrNext = {dmw1[27:25], vaddr[28:0]};
            memTypeNext = dmw1[5:4];
            excArgNext = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            paddr <= '0;
            memType <= '0;
            excArg <= '0;
        end
        else if (!stall)
        begin
            paddr <= paddrNext;
            memType <= memTypeNext;
            excArg <= excArgNext;
        end
    end

endmodule

//--- design/memoryMappingUnit.sv
`timescale 1ns/1ps

module memoryMappingUnit import mmuPkg::*;
(
    input logic clk,
    input logic reset,
    input logic [3:0] instrClass,
    input logic [4:0] subType,
    input logic [4:0] invOpIn,
    input logic [31:0] rj,
    input logic [31:0] rk,
    input logic stallW,
    input logic flushW,
    input logic [31:0] tlbIdxIn,
    input logic [31:0] tlbEhiIn,
    input logic [31:0] tlbElo0In,
    input logic [31:0] tlbElo1In,
    output logic [31:0] tlbIdxOut,
    output logic [31:0] tlbEhiOut,
    output logic [31:0] tlbElo0Out,
    output logic [31:0] tlbElo1Out,
    output logic [asidWidth-1:0] asidOut,
    input logic [8:0] crmd,
    input logic [asidWidth-1:0] asid,
    input logic [31:0] dmw0,
    input logic [31:0] dmw1,
    input logic stall0,
    input logic flush0,
    input logic [1:0] opType0,
    input logic vaddrValid0,
    input logic [31:0] vaddr0,
    output logic [31:0] paddr0,
    output logic [1:0] memType0,
    output logic [15:0] excArg0,
    input logic stall1,
    input logic flush1,
    input logic [1:0] opType1,
    input logic vaddrValid1,
    input logic [31:0] vaddr1,
    output logic [31:0] paddr1,
    output logic [1:0] memType1,
    output logic [15:0] excArg1
);

    logic [vppnWidth-1:0] searchVppn;
    logic [asidWidth-1:0] searchAsid;
    logic searchHit;
    logic [tlbIndexWidth-1:0] searchIndex;
    logic [tlbIndexWidth-1:0] readIndex;
    tlbEntry_t readEntry;
    logic writeEnable;
    logic [tlbIndexWidth-1:0] writeIndex;
    tlbEntry_t writeEntry;
    logic invEnable;
    logic [4:0] invOp;
    logic [asidWidth-1:0] invAsid;
    logic [31:0] invVaddr;

    tlbLookupIf lookup0 ();
    tlbLookupIf lookup1 ();

    tlbArray u_tlbArray
    (
        .clk(clk), .reset(reset),
        .lookup0(lookup0), .lookup1(lookup1),
        .searchVppn(searchVppn), .searchAsid(searchAsid), .readIndex(readIndex),
        .searchHit(searchHit), .searchIndex(searchIndex), .readEntry(readEntry),
        .writeEnable(writeEnable), .writeIndex(writeIndex), .writeEntry(writeEntry),
        .invEnable(invEnable), .invOp(invOp), .invAsid(invAsid), .invVaddr(invVaddr)
    );

    tlbCommandUnit u_tlbCommandUnit
    (
        .clk(clk), .reset(reset),
        .instrClass(instrClass), .subType(subType), .invOpIn(invOpIn),
        .rj(rj), .rk(rk), .stallW(stallW), .flushW(flushW),
        .tlbIdxIn(tlbIdxIn), .tlbEhiIn(tlbEhiIn),
        .tlbElo0In(tlbElo0In), .tlbElo1In(tlbElo1In), .asidIn(asid),
        .tlbIdxOut(tlbIdxOut), .tlbEhiOut(tlbEhiOut),
        .tlbElo0Out(tlbElo0Out), .tlbElo1Out(tlbElo1Out), .asidOut(asidOut),
        .searchVppn(searchVppn), .searchAsid(searchAsid),
        .searchHit(searchHit), .searchIndex(searchIndex),
        .readIndex(readIndex), .readEntry(readEntry),
        .writeEnable(writeEnable), .writeIndex(writeIndex), .writeEntry(writeEntry),
        .invEnable(invEnable), .invOp(invOp), .invAsid(invAsid), .invVaddr(invVaddr)
    );

    addrTranslator u_port0 // fetch
    (
        .clk(clk), .reset(reset), .stall(stall0), .flush(flush0),
        .vaddrValid(vaddrValid0), .vaddr(vaddr0), .opType(opType0),
        .crmd(crmd), .asid(asid), .dmw0(dmw0), .dmw1(dmw1),
        .lookup(lookup0),
        .paddr(paddr0), .memType(memType0), .excArg(excArg0)
    );

    addrTranslator u_port1 // load/store
    (
        .clk(clk), .reset(reset), .stall(stall1), .flush(flush1),
        .vaddrValid(vaddrValid1), .vaddr(vaddr1), .opType(opType1),
        .crmd(crmd), .asid(asid), .dmw0(dmw0), .dmw1(dmw1),
        .lookup(lookup1),
        .paddr(paddr1), .memType(memType1), .excArg(excArg1)
    );

endmodule

//--- design/mmuPkg.sv
package mmuPkg;

    localparam int tlbIndexWidth = 4;
    localparam int tlbEntries = 1 << tlbIndexWidth;
    localparam int vppnWidth = 19; // vaddr[31:13]
    localparam int ppnWidth = 20; // paddr[31:12]
    localparam int asidWidth = 10;

    localparam logic [1:0] opFetch = 2'd0;
    localparam logic [1:0] opLoad = 2'd1;
    localparam logic [1:0] opStore = 2'd2;

    localparam logic [3:0] classPrivMmu = 4'd10;
    localparam logic [3:0] classMmu = 4'd11;

    localparam logic [4:0] cmdTlbSrch = 5'd1;
    localparam logic [4:0] cmdTlbRd = 5'd2;
    localparam logic [4:0] cmdTlbWr = 5'd3;
    localparam logic [4:0] cmdTlbFill = 5'd4;
    localparam logic [4:0] cmdInvTlb = 5'd5;

    // exception argument is {valid, subcode, code}
    localparam logic [8:0] excSubDefault = 9'h0;
    localparam logic [5:0] excPil = 6'h01;
    localparam logic [5:0] excPis = 6'h02;
    localparam logic [5:0] excPif = 6'h03;
    localparam logic [5:0] excPme = 6'h04;
    localparam logic [5:0] excPpi = 6'h07;
    localparam logic [5:0] excTlbr = 6'h3f;

    typedef struct packed {
        logic [ppnWidth-1:0] ppn;
        logic [1:0] mat;
        logic [1:0] plv;
        logic dirty;
        logic valid;
    } tlbPage_t;

    typedef struct packed {
        logic exists;
        logic [vppnWidth-1:0] vppn;
        logic [5:0] ps; // page size as log2 bytes
        logic isGlobal;
        logic [asidWidth-1:0] asid;
        tlbPage_t even;
        tlbPage_t odd;
    } tlbEntry_t;

endpackage

//--- design/tlbArray.sv
`timescale 1ns/1ps

module tlbArray import mmuPkg::*;
(
    input logic clk,
    input logic reset,
    tlbLookupIf.array lookup0,
    tlbLookupIf.array lookup1,
    input logic [vppnWidth-1:0] searchVppn,
    input logic [asidWidth-1:0] searchAsid,
    input logic [tlbIndexWidth-1:0] readIndex,
    output logic searchHit,
    output logic [tlbIndexWidth-1:0] searchIndex,
    output tlbEntry_t readEntry,
    input logic writeEnable,
    input logic [tlbIndexWidth-1:0] writeIndex,
    input tlbEntry_t writeEntry,
    input logic invEnable,
    input logic [4:0] invOp,
    input logic [asidWidth-1:0] invAsid,
    input logic [31:0] invVaddr
);

    tlbEntry_t entries [tlbEntries];
    tlbEntry_t current [tlbEntries];
    logic [tlbEntries-1:0] existsBits;
    logic [tlbEntries-1:0] look0Vec;
    logic [tlbEntries-1:0] look1Vec;
    logic [tlbEntries-1:0] searchVec;
    logic [tlbEntries-1:0] invHit;
    logic [tlbIndexWidth-1:0] look0Index;
    logic [tlbIndexWidth-1:0] look1Index;

    // vppn bits that lie above the page size
    function automatic logic vppnMatch(input tlbEntry_t e, input logic [vppnWidth-1:0] vppn);
        logic [vppnWidth-1:0] mask;
        mask = {vppnWidth{1'b1}} << (e.ps - 6'd12);
        return ((e.vppn ^ vppn) & mask) == '0;
    endfunction

    function automatic logic entryMatch(input tlbEntry_t e, input logic [vppnWidth-1:0] vppn,
                                        input logic [asidWidth-1:0] asid);
        return e.exists && (e.isGlobal || e.asid == asid) && vppnMatch(e, vppn);
    endfunction

    function automatic logic invSelect(input tlbEntry_t e, input logic [4:0] op,
                                       input logic [asidWidth-1:0] asid,
                                       input logic [vppnWidth-1:0] vppn);
        logic asidEq;
        logic vaEq;
        logic sel;
        asidEq = e.asid == asid;
        vaEq = vppnMatch(e, vppn);
        case (op)
            5'd0, 5'd1: sel = 1'b1; // everything
            5'd2: sel = e.isGlobal;
            5'd3: sel = !e.isGlobal;
            5'd4: sel = !e.isGlobal && asidEq;
            5'd5: sel = !e.isGlobal && asidEq && vaEq;
            5'd6: sel = (e.isGlobal || asidEq) && vaEq;
            default: sel = 1'b0;
        endcase
        return sel;
    endfunction

    // lowest matching index wins
    function automatic logic [tlbIndexWidth-1:0] firstIndex(input logic [tlbEntries-1:0] vec);
        logic [tlbIndexWidth-1:0] idx;
        idx = '0;
        for (int i = tlbEntries - 1; i >= 0; i--)
        begin
            if (vec[i])
                idx = tlbIndexWidth'(i);
        end
        return idx;
    endfunction

    always_comb
    begin
        for (int i = 0; i < tlbEntries; i++)
        begin
            current[i] = entries[i];
            current[i].exists = existsBits[i];
            look0Vec[i] = entryMatch(current[i], lookup0.vaddr[31:13], lookup0.asid);
            look1Vec[i] = entryMatch(current[i], lookup1.vaddr[31:13], lookup1.asid);
            searchVec[i] = entryMatch(current[i], searchVppn, searchAsid);
            invHit[i] = invSelect(current[i], invOp, invAsid, invVaddr[31:13]);
        end
    end

    assign look0Index = firstIndex(look0Vec);
    assign look1Index = firstIndex(look1Vec);

    assign lookup0.hit = |look0Vec;
    assign lookup0.entry = (|look0Vec) ? current[look0Index] : '0;
    assign lookup1.hit = |look1Vec;
    assign lookup1.entry = (|look1Vec) ? current[look1Index] : '0;

    assign searchHit = |searchVec;
    assign searchIndex = firstIndex(searchVec);
    assign readEntry = current[readIndex];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            existsBits <= '0;
        end
        else if (writeEnable)
        begin
            existsBits[writeIndex] <= writeEntry.exists; // carries ~NE
        end
        else if (invEnable)
        begin
            existsBits <= existsBits & ~invHit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            entries[writeIndex] <= writeEntry;
        end
    end

endmodule

//--- design/tlbCommandUnit.sv
`timescale 1ns/1ps

module tlbCommandUnit import mmuPkg::*;
(
    input logic clk,
    input logic reset,
    input logic [3:0] instrClass,
    input logic [4:0] subType,
    input logic [4:0] invOpIn,
    input logic [31:0] rj,
    input logic [31:0] rk,
    input logic stallW,
    input logic flushW,
    input logic [31:0] tlbIdxIn,
    input logic [31:0] tlbEhiIn,
    input logic [31:0] tlbElo0In,
    input logic [31:0] tlbElo1In,
    input logic [asidWidth-1:0] asidIn,
    output logic [31:0] tlbIdxOut,
    output logic [31:0] tlbEhiOut,
    output logic [31:0] tlbElo0Out,
    output logic [31:0] tlbElo1Out,
    output logic [asidWidth-1:0] asidOut,
    output logic [vppnWidth-1:0] searchVppn,
    output logic [asidWidth-1:0] searchAsid,
    input logic searchHit,
    input logic [tlbIndexWidth-1:0] searchIndex,
    output logic [tlbIndexWidth-1:0] readIndex,
    input tlbEntry_t readEntry,
    output logic writeEnable,
    output logic [tlbIndexWidth-1:0] writeIndex,
    output tlbEntry_t writeEntry,
    output logic invEnable,
    output logic [4:0] invOp,
    output logic [asidWidth-1:0] invAsid,
    output logic [31:0] invVaddr
);

    logic mmuClass;
    logic execute;
    logic [31:0] idxNext;
    logic [31:0] ehiNext;
    logic [31:0] elo0Next;
    logic [31:0] elo1Next;
    logic [asidWidth-1:0] asidNext;

    // ELO layout {ppn[27:8], g[6], mat[5:4], plv[3:2], d[1], v[0]}
    function automatic logic [31:0] packElo(input tlbPage_t p, input logic g);
        return {4'b0, p.ppn, 1'b0, g, p.mat, p.plv, p.dirty, p.valid};
    endfunction

    function automatic tlbPage_t unpackElo(input logic [31:0] elo);
        return '{ppn: elo[27:8], mat: elo[5:4], plv: elo[3:2], dirty: elo[1], valid: elo[0]};
    endfunction

    assign mmuClass = instrClass == classMmu || instrClass == classPrivMmu;
    assign execute = mmuClass && !stallW;

    assign searchVppn = tlbEhiIn[31:13];
    assign searchAsid = asidIn;
    assign readIndex = tlbIdxIn[tlbIndexWidth-1:0];

    assign writeEnable = execute && (subType == cmdTlbWr || subType == cmdTlbFill);
    assign writeIndex = tlbIdxIn[tlbIndexWidth-1:0]; // fill uses the given index too
    assign writeEntry = '{exists: !tlbIdxIn[31], vppn: tlbEhiIn[31:13], ps: tlbIdxIn[29:24],
                          isGlobal: tlbElo0In[6] & tlbElo1In[6], asid: asidIn,
                          even: unpackElo(tlbElo0In), odd: unpackElo(tlbElo1In)};

    assign invEnable = execute && subType == cmdInvTlb;
    assign invOp = invOpIn;
    assign invAsid = rj[asidWidth-1:0];
    assign invVaddr = rk;

    always_comb
    begin
        idxNext = tlbIdxIn;
        ehiNext = tlbEhiIn;
        elo0Next = tlbElo0In;
        elo1Next = tlbElo1In;
        asidNext = asidIn;
        if (mmuClass && subType == cmdTlbSrch)
        begin
            idxNext[31] = !searchHit; // NE
            if (searchHit)
                idxNext[tlbIndexWidth-1:0] = searchIndex;
        end
        else if (mmuClass && subType == cmdTlbRd)
        begin
            if (readEntry.exists)
            begin
                idxNext[31] = 1'b0;
                idxNext[29:24] = readEntry.ps;
                ehiNext = {readEntry.vppn, 13'b0};
                elo0Next = packElo(readEntry.even, readEntry.isGlobal);
                elo1Next = packElo(readEntry.odd, readEntry.isGlobal);
                asidNext = readEntry.asid;
            end
            else
            begin
                idxNext = {1'b1, 31'b0}; // empty slot reads as NE
                ehiNext = '0;
                elo0Next = '0;
                elo1Next = '0;
                asidNext = '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flushW)
        begin
            tlbIdxOut <= '0;
            tlbEhiOut <= '0;
            tlbElo0Out <= '0;
            tlbElo1Out <= '0;
            asidOut <= '0;
        end
        else if (!stallW)
        begin
            tlbIdxOut <= idxNext;
            tlbEhiOut <= ehiNext;
            tlbElo0Out <= elo0Next;
            tlbElo1Out <= elo1Next;
            asidOut <= asidNext;
        end
    end

endmodule

//--- design/tlbLookupIf.sv
`timescale 1ns/1ps

interface tlbLookupIf import mmuPkg::*; ();

    logic [31:0] vaddr;
    logic [asidWidth-1:0] asid;
    logic hit;
    tlbEntry_t entry; // zero on miss

    modport translator
    (
        output vaddr,
        output asid,
        input hit,
        input entry
    );

    // combinational answer in the same cycle
    modport array
    (
        input vaddr,
        input asid,
        output hit,
        output entry
    );

endinterface

//--- dv/mmuPatterns.txt
# mgmt  0 class sub invop rj rk idx ehi elo0 elo1 asid | idxOut ehiOut elo0Out elo1Out asidOut
# xlat  1 crmd asid dmw0 dmw1 op0 v0 va0 op1 v1 va1 randmask | pa0 mt0 exc0 pa1 mt1 exc1
# stall 2 va0 va1 (outputs hold)    flush 3 (outputs zero)
1 128 005 a0000011 82000008 0 1 12340000 1 1 9abc0000 0000ffff 12340000 1 0000 9abc0000 2 0000
1 010 005 a0000011 82000008 0 1 00400000 2 1 00401000 00000000 00000000 0 803f 00000000 0 803f
0 b 3 00 0 0 0c000000 00400000 01234513 00abcd0d 005 0c000000 00400000 01234513 00abcd0d 005
0 a 4 00 0 0 16000001 10000000 0040005f 008c0060 005 16000001 10000000 0040005f 008c0060 005
0 b 3 00 0 0 0c000002 00400000 02222213 03333313 006 0c000002 00400000 02222213 03333313 006
0 b 1 00 0 0 0000000f 00400000 0 0 005 00000000 00400000 0 0 005
0 b 1 00 0 0 00000000 00401000 0 0 006 00000002 00401000 0 0 006
0 b 1 00 0 0 00000000 30000000 0 0 005 80000000 30000000 0 0 005
0 b 1 00 0 0 00000000 10600000 0 0 3ff 00000001 10600000 0 0 3ff
0 b 2 00 0 0 00000001 0 0 0 003 16000001 10000000 0040005f 008c0060 005
0 b 2 00 0 0 00000000 0 0 0 003 0c000000 00400000 01234513 00abcd0d 005
0 b 2 00 0 0 00000005 0 0 0 003 80000000 0 0 0 000
1 010 005 a0000011 82000008 0 1 00400000 1 1 00401000 00000fff 12345000 1 0000 0abcd000 0 0000
1 010 005 a0000011 82000008 0 1 10123456 2 1 00401000 00000000 04123456 1 0000 0abcd000 0 8004
1 010 005 a0000011 82000008 0 1 10400000 1 1 10523456 00000000 08c00000 2 8003 08d23456 2 8001
1 010 005 a0000011 82000008 0 0 20000000 2 1 10523456 00000000 00000000 0 003f 08d23456 2 8002
1 010 006 a0000011 82000008 0 1 00400000 1 1 10000000 00000fff 22222000 1 0000 04000000 1 0000
1 013 005 a0000011 82000008 0 1 00400000 1 1 80001234 00000000 12345000 1 8007 20001234 0 0000
1 010 005 a0000011 82000008 0 1 a0001000 1 1 80001234 00000000 00001000 1 0000 00000000 0 803f
2 11111000 22222000
3
0 b 5 05 00000005 00400000 0 0 0 0 005 0 0 0 0 005
0 b 1 00 0 0 0 00400000 0 0 005 80000000 00400000 0 0 005
0 b 1 00 0 0 0 00400000 0 0 006 00000002 00400000 0 0 006
0 b 5 04 00000006 00000000 0 0 0 0 006 0 0 0 0 006
0 b 1 00 0 0 0 00400000 0 0 006 80000000 00400000 0 0 006
0 b 3 00 0 0 0c000000 00400000 01234513 00abcd0d 005 0c000000 00400000 01234513 00abcd0d 005
0 b 3 00 0 0 0c000002 00400000 02222213 03333313 006 0c000002 00400000 02222213 03333313 006
0 b 5 06 00000005 00400000 0 0 0 0 005 0 0 0 0 005
0 b 1 00 0 0 0 00400000 0 0 005 80000000 00400000 0 0 005
0 b 1 00 0 0 0 00400000 0 0 006 00000002 00400000 0 0 006
0 b 5 03 00000000 00000000 0 0 0 0 005 0 0 0 0 005
0 b 1 00 0 0 0 00400000 0 0 006 80000000 00400000 0 0 006
0 b 1 00 0 0 0 10000000 0 0 3ff 00000001 10000000 0 0 3ff
0 b 3 00 0 0 0c000000 00400000 01234513 00abcd0d 005 0c000000 00400000 01234513 00abcd0d 005
0 b 5 02 00000000 00000000 0 0 0 0 005 0 0 0 0 005
1 010 005 a0000011 82000008 0 1 00400000 1 1 10000000 00000000 12345000 1 0000 00000000 0 803f
0 b 5 00 00000000 00000000 0 0 0 0 005 0 0 0 0 005
1 010 005 a0000011 82000008 0 1 00400000 1 0 00401000 00000000 00000000 0 803f 00000000 0 003f

//--- dv/mmuTb.sv
`timescale 1ns/1ps

module mmuTb import mmuPkg::*; ();

    logic clk;
    logic reset;
    logic [3:0] instrClass;
    logic [4:0] subType;
    logic [4:0] invOpIn;
    logic [31:0] rj;
    logic [31:0] rk;
    logic stallW;
    logic flushW;
    logic [31:0] tlbIdxIn;
    logic [31:0] tlbEhiIn;
    logic [31:0] tlbElo0In;
    logic [31:0] tlbElo1In;
    logic [31:0] tlbIdxOut;
    logic [31:0] tlbEhiOut;
    logic [31:0] tlbElo0Out;
    logic [31:0] tlbElo1Out;
    logic [asidWidth-1:0] asidOut;
    logic [8:0] crmd;
    logic [asidWidth-1:0] asid;
    logic [31:0] dmw0;
    logic [31:0] dmw1;
    logic stall0;
    logic flush0;
    logic [1:0] opType0;
    logic vaddrValid0;
    logic [31:0] vaddr0;
    logic [31:0] paddr0;
    logic [1:0] memType0;
    logic [15:0] excArg0;
    logic stall1;
    logic flush1;
    logic [1:0] opType1;
    logic vaddrValid1;
    logic [31:0] vaddr1;
    logic [31:0] paddr1;
    logic [1:0] memType1;
    logic [15:0] excArg1;

    logic [31:0] lfsrState;
    logic [31:0] expPa0;
    logic [31:0] expPa1;
    logic [31:0] expMt0;
    logic [31:0] expMt1;
    logic [31:0] expExc0;
    logic [31:0] expExc1;

    memoryMappingUnit u_dut (.*);

    always #50 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomUnder(input logic [31:0] mask, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < 32; i++)
        begin
            if (mask[i])
            begin
                lfsrState = lfsrNext(lfsrState);
                bits[i] = lfsrState[0];
            end
        end
    endtask

    task automatic stopRun(input string reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stopRun("output value mismatch");
        end
    endtask

    // returns just after the next falling edge
    task automatic waitFallingEdge;
        int guard;
        guard = 0;
        while (clk !== 1'b1 && guard < 200)
        begin
            #1;
            guard++;
        end
        while (clk !== 1'b0 && guard < 200)
        begin
            #1;
            guard++;
        end
        if (guard >= 200)
            stopRun("clock stopped toggling while waiting for a falling edge");
    endtask

    task automatic checkPorts;
        checkValue("paddr0", paddr0, expPa0);
        checkValue("memType0", 32'(memType0), expMt0);
        checkValue("excArg0", 32'(excArg0), expExc0);
        checkValue("paddr1", paddr1, expPa1);
        checkValue("memType1", 32'(memType1), expMt1);
        checkValue("excArg1", 32'(excArg1), expExc1);
    endtask

    task automatic quietInputs;
        {instrClass, subType, invOpIn, rj, rk, stallW, flushW} = '0;
        {tlbIdxIn, tlbEhiIn, tlbElo0In, tlbElo1In} = '0;
        {stall0, flush0, stall1, flush1, vaddrValid0, vaddrValid1} = '0;
    endtask

    initial
    begin
        int fd;
        int n;
        int steps;
        string line;
        logic [31:0] fld [18];
        logic [31:0] r;
        clk = 1'b0;
        reset = 1'b1;
        lfsrState = 32'hf4f3c85b;
        quietInputs();
        {crmd, asid, dmw0, dmw1, opType0, opType1, vaddr0, vaddr1} = '0;
        {expPa0, expPa1, expMt0, expMt1, expExc0, expExc1} = '0;
        // write and lookups held off by reset
        instrClass = classMmu;
        subType = cmdTlbWr;
        tlbIdxIn = 32'h0c000000;
        tlbEhiIn = 32'h00400000;
        tlbElo0In = 32'h01234513;
        tlbElo1In = 32'h00abcd0d;
        asid = 10'h005;
        vaddrValid0 = 1'b1;
        vaddrValid1 = 1'b1;
        vaddr0 = 32'h00400000;
        vaddr1 = 32'h00401000;
        steps = 0;
        #0.5;
        for (int i = 0; i < 16; i++)
            waitFallingEdge();
        reset = 1'b0;
        checkPorts(); // all zero out of reset
        checkValue("tlbIdxOut", tlbIdxOut, 32'h0);
        checkValue("tlbEhiOut", tlbEhiOut, 32'h0);
        checkValue("tlbElo0Out", tlbElo0Out, 32'h0);
        checkValue("tlbElo1Out", tlbElo1Out, 32'h0);
        checkValue("asidOut", 32'(asidOut), 32'h0);
        fd = $fopen("dv/mmuPatterns.txt", "r");
        if (fd == 0)
            stopRun("cannot open dv/mmuPatterns.txt");
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == 8'h23)
                continue;
            n = $sscanf(line, "%h", fld[0]);
            if (n != 1)
                stopRun("pattern line has no step kind");
            quietInputs();
            case (fld[0])
                32'd0: // management
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                                fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                                fld[15]);
                    if (n != 16)
                        stopRun("management line does not have 16 fields");
                    instrClass = fld[1][3:0];
                    subType = fld[2][4:0];
                    invOpIn = fld[3][4:0];
                    rj = fld[4];
                    rk = fld[5];
                    tlbIdxIn = fld[6];
                    tlbEhiIn = fld[7];
                    tlbElo0In = fld[8];
                    tlbElo1In = fld[9];
                    asid = fld[10][asidWidth-1:0];
                    waitFallingEdge();
                    checkValue("tlbIdxOut", tlbIdxOut, fld[11]);
                    checkValue("tlbEhiOut", tlbEhiOut, fld[12]);
                    checkValue("tlbElo0Out", tlbElo0Out, fld[13]);
                    checkValue("tlbElo1Out", tlbElo1Out, fld[14]);
                    checkValue("asidOut", 32'(asidOut), fld[15]);
                end
                32'd1: // translate on both ports
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                                fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                                fld[15], fld[16], fld[17]);
                    if (n != 18)
                        stopRun("translate line does not have 18 fields");
                    randomUnder(fld[11], r); // same offset bits on both ports
                    crmd = fld[1][8:0];
                    asid = fld[2][asidWidth-1:0];
                    dmw0 = fld[3];
                    dmw1 = fld[4];
                    opType0 = fld[5][1:0];
                    vaddrValid0 = fld[6][0];
                    vaddr0 = fld[7] | r;
                    opType1 = fld[8][1:0];
                    vaddrValid1 = fld[9][0];
                    vaddr1 = fld[10] | r;
                    expPa0 = fld[12] | r;
                    expMt0 = fld[13];
                    expExc0 = fld[14];
                    expPa1 = fld[15] | r;
                    expMt1 = fld[16];
                    expExc1 = fld[17];
                    waitFallingEdge();
                    checkPorts();
                end
                32'd2: // stall, new addresses must not get through
                begin
                    n = $sscanf(line, "%h %h %h", fld[0], fld[1], fld[2]);
                    if (n != 3)
                        stopRun("stall line does not have 3 fields");
                    stall0 = 1'b1;
                    stall1 = 1'b1;
                    crmd = 9'h008; // direct mode would pass the new addresses through
                    vaddrValid0 = 1'b1;
                    vaddrValid1 = 1'b1;
                    vaddr0 = fld[1];
                    vaddr1 = fld[2];
                    waitFallingEdge();
                    checkPorts();
                end
                32'd3: // flush ports and management outputs
                begin
                    flush0 = 1'b1;
                    flush1 = 1'b1;
                    flushW = 1'b1;
                    {expPa0, expPa1, expMt0, expMt1, expExc0, expExc1} = '0;
                    waitFallingEdge();
                    checkPorts();
                    checkValue("tlbIdxOut", tlbIdxOut, 32'h0);
                    checkValue("tlbEhiOut", tlbEhiOut, 32'h0);
                    checkValue("tlbElo0Out", tlbElo0Out, 32'h0);
                    checkValue("tlbElo1Out", tlbElo1Out, 32'h0);
                    checkValue("asidOut", 32'(asidOut), 32'h0);
                end
                default:
                    stopRun("pattern line has an unknown step kind");
            endcase
            steps++;
        end
        $fclose(fd);
        if (steps == 0)
        begin
            stopRun("pattern file holds no steps");
        end
        else
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds and runs the MMU testbench, exit status follows the simulation
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module mmuTb -o mmuSim

./obj_dir/mmuSim

//--- sim.f
design/mmuPkg.sv
design/tlbLookupIf.sv
design/tlbArray.sv
design/tlbCommandUnit.sv
design/addrTranslator.sv
design/memoryMappingUnit.sv
dv/mmuTb.sv
